/* run_sim.sh */
#!/bin/sh
# Build and run the I/O section testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary -f sources.f --top-module io_tb -o io_sim || exit 1
out="$(./obj_dir/io_sim)"
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS" && exit 0 || exit 1

/* source/io_cmd_pkg.sv */
`default_nettype none

`include "io_consts.svh"

package io_cmd_pkg;

   // Control store write command (COMM field)
   typedef enum logic [`IO_CS_W-1:0] {
      comm_none    = 5'd0,
      comm_uart_tx = 5'd4,   // Load UART transmitter
      comm_ctrl    = 5'd6,   // Load I/O control register
      comm_pan_out = 5'd9    // Load panel output latch
   } io_comm_e;

   // Control store IDB source (IDBS field)
   typedef enum logic [`IO_CS_W-1:0] {
      idbs_none    = 5'd0,
      idbs_uart_rx = 5'd3,   // Pops rx FIFO
      idbs_status  = 5'd5,
      idbs_ctrl    = 5'd6,
      idbs_pan_in  = 5'd10   // Pops panel FIFO
   } io_idbs_e;

endpackage

`default_nettype wire

/* source/io_consts.svh */
`ifndef IO_CONSTS_SVH
`define IO_CONSTS_SVH

// Internal data bus
`define IO_IDB_W 16

// UART character width
`define IO_BYTE_W 8

// Microinstruction field width, both COMM and IDBS
`define IO_CS_W 5

`define IO_FIFO_DEPTH 4

// Clocks per bit at baud switch 0
`define IO_BAUD_BASE 4
`define IO_BAUD_SEL_W 4

// Wide enough for base << 15
`define IO_BAUD_CNT_W 18

`endif

/* source/io_data_pkg.sv */
`default_nettype none

`include "io_consts.svh"

package io_data_pkg;

   typedef logic [`IO_BYTE_W-1:0] uart_byte_t;
   typedef logic [`IO_IDB_W-1:0]  panel_word_t;

   typedef struct packed {
      logic [`IO_IDB_W-6:0] zero;  // Always read as zero
      logic pan_full;
      logic rx_full;
      logic pan_avail;
      logic tx_empty;
      logic rx_avail;
   } io_status_t;

   typedef struct packed {
      logic [`IO_IDB_W-4:0] spare; // Stored, no function
      logic pan_ie;
      logic tx_ie;
      logic rx_ie;
   } io_ctrl_t;

endpackage

`default_nettype wire

/* source/io_decode.sv */
`default_nettype none

`include "io_consts.svh"

// Stands in for the I/O decode PAL
module io_decode (
   input  logic               sysclk,
   input  logic               rst,
   input  logic [`IO_CS_W-1:0] cs_comm,
   input  logic [`IO_CS_W-1:0] cs_idbs,
   input  logic               cs_valid,
   output logic               uart_wr,
   output logic               ctrl_wr,
   output logic               pan_wr,
   output logic               uart_rd,
   output logic               pan_rd,
   output logic               sel_status,
   output logic               sel_ctrl
);

   // Write strobes
   always_comb begin
      uart_wr = cs_valid && (cs_comm == io_cmd_pkg::comm_uart_tx);
      ctrl_wr = cs_valid && (cs_comm == io_cmd_pkg::comm_ctrl);
      pan_wr  = cs_valid && (cs_comm == io_cmd_pkg::comm_pan_out);
   end

   // Read selects double as FIFO pops
   always_comb begin
      uart_rd    = cs_valid && (cs_idbs == io_cmd_pkg::idbs_uart_rx);
      pan_rd     = cs_valid && (cs_idbs == io_cmd_pkg::idbs_pan_in);
      sel_status = cs_valid && (cs_idbs == io_cmd_pkg::idbs_status);
      sel_ctrl   = cs_valid && (cs_idbs == io_cmd_pkg::idbs_ctrl);
   end

endmodule

`default_nettype wire

/* source/io_fifo.sv */
`default_nettype none

`include "io_consts.svh"

module io_fifo #(
   parameter type entry_t = logic [`IO_BYTE_W-1:0],
   parameter int  DEPTH   = `IO_FIFO_DEPTH
) (
   input  logic   sysclk,
   input  logic   rst,
   input  logic   push,
   input  entry_t wdata,
   input  logic   pop,
   output entry_t rdata,
   output logic   not_empty,
   output logic   full
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   entry_t           mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign full      = count == CNT_W'(DEPTH);
   assign not_empty = count != '0;
   assign do_push   = push && !full;      // Dropped when full
   assign do_pop    = pop && not_empty;
   assign rdata     = not_empty ? mem[rd_ptr] : '0;

   always_ff @(posedge sysclk) begin
      if (do_push)
         mem[wr_ptr] <= wdata;
   end

   always_ff @(posedge sysclk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

/* source/io_panel.sv */
`default_nettype none

`include "io_consts.svh"

module io_panel (
   input  logic                     sysclk,
   input  logic                     rst,
   input  logic [`IO_IDB_W-1:0]      idb_in,
   input  logic                     pan_wr,
   input  logic                     pan_rd,
   input  io_data_pkg::panel_word_t pan_word,
   input  logic                     pan_strobe,
   output logic [`IO_IDB_W-1:0]      idb_out,
   output io_data_pkg::panel_word_t pan_out,
   output logic                     pan_avail,
   output logic                     pan_full
);

   io_data_pkg::panel_word_t pan_head;

   // Words from the operator panel, waiting for the CPU
   io_fifo #(
      .entry_t (io_data_pkg::panel_word_t),
      .DEPTH   (`IO_FIFO_DEPTH)
   ) pan_fifo (
      .sysclk    (sysclk),
      .rst       (rst),
      .push      (pan_strobe),
      .wdata     (pan_word),
      .pop       (pan_rd),
      .rdata     (pan_head),
      .not_empty (pan_avail),
      .full      (pan_full)
   );

   always_ff @(posedge sysclk) begin
      if (rst)
         pan_out <= '0;
      else if (pan_wr)
         pan_out <= io_data_pkg::panel_word_t'(idb_in);  // Held until next write
   end

   assign idb_out = pan_rd ? `IO_IDB_W'(pan_head) : '0;

endmodule

`default_nettype wire

/* source/io_reg.sv */
`default_nettype none

`include "io_consts.svh"

module io_reg (
   input  logic                sysclk,
   input  logic                rst,
   input  logic [`IO_IDB_W-1:0] idb_in,
   input  logic                ctrl_wr,
   input  logic                sel_status,
   input  logic                sel_ctrl,
   input  logic                rx_avail,
   input  logic                rx_full,
   input  logic                tx_empty,
   input  logic                pan_avail,
   input  logic                pan_full,
   output logic [`IO_IDB_W-1:0] idb_out,
   output logic                bint10,
   output logic                bint12,
   output logic                bint13
);

   io_data_pkg::io_ctrl_t   ctrl;
   io_data_pkg::io_status_t status;

   always_ff @(posedge sysclk) begin
      if (rst)
         ctrl <= '0;
      else if (ctrl_wr)
         ctrl <= io_data_pkg::io_ctrl_t'(idb_in);
   end

   always_comb begin
      status           = '0;
      status.rx_avail  = rx_avail;
      status.tx_empty  = tx_empty;
      status.pan_avail = pan_avail;
      status.rx_full   = rx_full;
      status.pan_full  = pan_full;
   end

   // Zero unless selected
   assign idb_out = (sel_status ? `IO_IDB_W'(status) : '0) |
                    (sel_ctrl   ? `IO_IDB_W'(ctrl)   : '0);

   // Interrupt lines, one cycle behind their sources
   always_ff @(posedge sysclk) begin
      if (rst) begin
         bint10 <= 1'b0;
         bint12 <= 1'b0;
         bint13 <= 1'b0;
      end else begin
         bint10 <= rx_avail  && ctrl.rx_ie;   // Character received
         bint12 <= tx_empty  && ctrl.tx_ie;   // Transmitter ready
         bint13 <= pan_avail && ctrl.pan_ie;  // Panel word waiting
      end
   end

endmodule

`default_nettype wire

/* source/io_top.sv */
`default_nettype none

`include "io_consts.svh"

module io_top (
   input  logic                     sysclk,
   input  logic                     rst,
   input  logic [`IO_CS_W-1:0]       cs_comm,
   input  logic [`IO_CS_W-1:0]       cs_idbs,
   input  logic                     cs_valid,
   input  logic [`IO_IDB_W-1:0]      idb_in,
   input  logic                     rxd,
   input  logic [`IO_BAUD_SEL_W-1:0] baud_sel,
   input  io_data_pkg::panel_word_t pan_word,
   input  logic                     pan_strobe,
   output logic [`IO_IDB_W-1:0]      idb_out,
   output logic                     txd,
   output io_data_pkg::panel_word_t pan_out,
   output logic                     bint10,
   output logic                     bint12,
   output logic                     bint13
);

   logic [`IO_IDB_W-1:0] uart_idb;
   logic [`IO_IDB_W-1:0] reg_idb;
   logic [`IO_IDB_W-1:0] pan_idb;
   logic uart_wr;
   logic ctrl_wr;
   logic pan_wr;
   logic uart_rd;
   logic pan_rd;
   logic sel_status;
   logic sel_ctrl;
   logic rx_avail;
   logic rx_full;
   logic tx_empty;
   logic pan_avail;
   logic pan_full;

   io_decode decode (
      .sysclk (sysclk),     .rst (rst),
      .cs_comm (cs_comm),   .cs_idbs (cs_idbs),   .cs_valid (cs_valid),
      .uart_wr (uart_wr),   .ctrl_wr (ctrl_wr),   .pan_wr (pan_wr),
      .uart_rd (uart_rd),   .pan_rd (pan_rd),
      .sel_status (sel_status), .sel_ctrl (sel_ctrl)
   );

   io_reg regs (
      .sysclk (sysclk),     .rst (rst),           .idb_in (idb_in),
      .ctrl_wr (ctrl_wr),   .sel_status (sel_status), .sel_ctrl (sel_ctrl),
      .rx_avail (rx_avail), .rx_full (rx_full),   .tx_empty (tx_empty),
      .pan_avail (pan_avail), .pan_full (pan_full),
      .idb_out (reg_idb),
      .bint10 (bint10),     .bint12 (bint12),     .bint13 (bint13)
   );

   // Console UART, clocked from sysclk
   io_uart uart (
      .sysclk (sysclk),     .rst (rst),           .baud_sel (baud_sel),
      .idb_in (idb_in),     .uart_wr (uart_wr),   .uart_rd (uart_rd),
      .rxd (rxd),           .idb_out (uart_idb),  .txd (txd),
      .tx_empty (tx_empty), .rx_avail (rx_avail), .rx_full (rx_full)
   );

   io_panel panel (
      .sysclk (sysclk),     .rst (rst),           .idb_in (idb_in),
      .pan_wr (pan_wr),     .pan_rd (pan_rd),
      .pan_word (pan_word), .pan_strobe (pan_strobe),
      .idb_out (pan_idb),   .pan_out (pan_out),
      .pan_avail (pan_avail), .pan_full (pan_full)
   );

   // Unselected devices drive zero, so OR is the bus
   assign idb_out = uart_idb | reg_idb | pan_idb;

endmodule

`default_nettype wire

/* source/io_uart.sv */
`default_nettype none

`include "io_consts.svh"

module io_uart (
   input  logic                    sysclk,
   input  logic                    rst,
   input  logic [`IO_BAUD_SEL_W-1:0] baud_sel,
   input  logic [`IO_IDB_W-1:0]     idb_in,
   input  logic                    uart_wr,
   input  logic                    uart_rd,
   input  logic                    rxd,
   output logic [`IO_IDB_W-1:0]     idb_out,
   output logic                    txd,
   output logic                    tx_empty,
   output logic                    rx_avail,
   output logic                    rx_full
);

   logic [`IO_BAUD_CNT_W-1:0] bit_len;
   logic [`IO_BAUD_CNT_W-1:0] half_len;
   logic [`IO_BAUD_CNT_W-1:0] tx_div;
   logic [`IO_BAUD_CNT_W-1:0] rx_div;
   logic [8:0]                tx_shift;  // Data then stop bit
   logic [3:0]                tx_bits;
   logic [3:0]                rx_bits;
   logic                      tx_busy;
   logic                      rx_busy;
   logic [1:0]                rxd_sync;
   logic                      rx_line;
   logic                      rx_tick;
   logic                      rx_push;
   io_data_pkg::uart_byte_t   rx_shift;
   io_data_pkg::uart_byte_t   rx_head;

   // Baud divider shared by both directions
   assign bit_len  = `IO_BAUD_CNT_W'(`IO_BAUD_BASE) << baud_sel;
   assign half_len = bit_len >> 1;

   assign tx_empty = !tx_busy;

   // Transmitter; start bit goes out right at the write edge
   always_ff @(posedge sysclk) begin
      if (rst) begin
         txd     <= 1'b1;
         tx_busy <= 1'b0;
         tx_div  <= '0;
         tx_bits <= '0;
      end else if (!tx_busy) begin
         if (uart_wr) begin
            txd     <= 1'b0;
            tx_busy <= 1'b1;
            tx_div  <= bit_len - 1'b1;
            tx_bits <= 4'd9;
         end
      end else if (tx_div != '0) begin
         tx_div <= tx_div - 1'b1;
      end else if (tx_bits == '0) begin
         tx_busy <= 1'b0;               // End of stop bit
      end else begin
         txd     <= tx_shift[0];
         tx_bits <= tx_bits - 1'b1;
         tx_div  <= bit_len - 1'b1;
      end
   end

   always_ff @(posedge sysclk) begin
      if (!tx_busy && uart_wr)
         tx_shift <= {1'b1, idb_in[`IO_BYTE_W-1:0]};
      else if (tx_busy && tx_div == '0 && tx_bits != '0)
         tx_shift <= {1'b1, tx_shift[8:1]};
   end

   assign rx_line = rxd_sync[1];
   assign rx_tick = rx_busy && rx_div == '0;       // Mid-bit sample point
   assign rx_push = rx_tick && rx_bits == 4'd9 && rx_line;

   // Receiver, sample 0 checks the start bit, 9 the stop bit
   always_ff @(posedge sysclk) begin
      if (rst) begin
         rxd_sync <= 2'b11;
         rx_busy  <= 1'b0;
         rx_div   <= '0;
         rx_bits  <= '0;
      end else begin
         rxd_sync <= {rxd_sync[0], rxd};
         if (!rx_busy) begin
            if (!rx_line) begin
               rx_busy <= 1'b1;
               rx_div  <= half_len - 1'b1;
               rx_bits <= '0;
            end
         end else if (rx_div != '0) begin
            rx_div <= rx_div - 1'b1;
         end else begin
            rx_div  <= bit_len - 1'b1;
            rx_bits <= rx_bits + 1'b1;
            if ((rx_bits == '0 && rx_line) || rx_bits == 4'd9)
               rx_busy <= 1'b0;          // Glitch or frame done
         end
      end
   end

   always_ff @(posedge sysclk) begin
      if (rx_tick && rx_bits != '0 && rx_bits != 4'd9)
         rx_shift <= {rx_line, rx_shift[`IO_BYTE_W-1:1]};  // LSB first
   end

   io_fifo #(
      .entry_t (io_data_pkg::uart_byte_t),
      .DEPTH   (`IO_FIFO_DEPTH)
   ) rx_fifo (
      .sysclk    (sysclk),
      .rst       (rst),
      .push      (rx_push),
      .wdata     (rx_shift),
      .pop       (uart_rd),
      .rdata     (rx_head),
      .not_empty (rx_avail),
      .full      (rx_full)
   );

   assign idb_out = uart_rd ? `IO_IDB_W'(rx_head) : '0;

endmodule

`default_nettype wire

/* sources.f */
+incdir+source
source/io_cmd_pkg.sv
source/io_data_pkg.sv
source/io_fifo.sv
source/io_decode.sv
source/io_reg.sv
source/io_uart.sv
source/io_panel.sv
source/io_top.sv
testbench/io_checker.sv
testbench/io_tb.sv

/* testbench/io_checker.sv */
`default_nettype none

module io_checker (
   input  logic        sysclk,
   input  logic        check_en,
   input  logic [2:0]  sig_sel,
   input  logic [15:0] exp_val,
   input  logic [7:0]  test_id,
   input  logic        test_done,
   input  logic        report,
   input  logic [15:0] idb_out,
   input  logic        txd,
   input  logic [15:0] pan_out,
   input  logic        bint10,
   input  logic        bint12,
   input  logic        bint13,
   output int          err_count,
   output int          check_count
);

   timeunit 1ns;
   timeprecision 1ps;

   int test_errs;
   int tests_run;

   function automatic string sig_name(input logic [2:0] sel);
      case (sel)
         3'd0:    return "idb_out";
         3'd1:    return "txd";
         3'd2:    return "pan_out";
         3'd3:    return "bint10";
         3'd4:    return "bint12";
         default: return "bint13";
      endcase
   endfunction

   function automatic logic [15:0] pick(input logic [2:0] sel);
      case (sel)
         3'd0:    return idb_out;
         3'd1:    return {15'd0, txd};
         3'd2:    return pan_out;
         3'd3:    return {15'd0, bint10};
         3'd4:    return {15'd0, bint12};
         default: return {15'd0, bint13};
      endcase
   endfunction

   initial begin
      err_count   = 0;
      check_count = 0;
      test_errs   = 0;
      tests_run   = 0;
   end

   // Values sampled at the edge that the row drove into
   always @(posedge sysclk) begin
      if (check_en) begin
         check_count <= check_count + 1;
         if (pick(sig_sel) !== exp_val) begin
            $display("ERR t=%0t %s expected %h got %h", $time, sig_name(sig_sel),
                     exp_val, pick(sig_sel));
            err_count <= err_count + 1;
            test_errs <= test_errs + 1;
         end
      end
      if (test_done) begin
         $display("test %0d %s (%0d errors)", test_id,
                  (test_errs == 0) ? "ok" : "failed", test_errs);
         tests_run <= tests_run + 1;
         test_errs <= 0;
      end
      if (report)
         $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, err_count);
   end

endmodule

`default_nettype wire

/* testbench/io_tb.sv */
`default_nettype none

`include "io_consts.svh"

module io_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [3:0] K_WR = 4'd0, K_RD = 4'd1, K_PUSH = 4'd2, K_WAIT = 4'd3;
   localparam logic [3:0] K_CHK = 4'd4, K_IDLE = 4'd5, K_BAUD = 4'd6, K_END = 4'd7;
   localparam logic [2:0] S_IDB = 3'd0, S_TXD = 3'd1, S_PAN = 3'd2;
   localparam logic [2:0] S_B10 = 3'd3, S_B12 = 3'd4, S_B13 = 3'd5;
   localparam logic [4:0] NO_SLOT = 5'd31;

   typedef struct packed {
      logic [3:0]  kind;
      logic [4:0]  code;
      logic [15:0] data;
      logic [15:0] exp;
      logic [2:0]  sig;
      logic [7:0]  test;
   } row_t;

   logic        sysclk;
   logic        rst;
   logic [4:0]  cs_comm;
   logic [4:0]  cs_idbs;
   logic        cs_valid;
   logic [15:0] idb_in;
   logic        rxd;
   logic [3:0]  baud_sel;
   logic [15:0] pan_word;
   logic        pan_strobe;
   logic [15:0] idb_out;
   logic        txd;
   logic [15:0] pan_out;
   logic        bint10;
   logic        bint12;
   logic        bint13;
   logic        check_en;
   logic [2:0]  sig_sel;
   logic [15:0] exp_val;
   logic [7:0]  test_id;
   logic        test_done;
   logic        report;
   int          err_count;
   int          check_count;

   row_t        rows [128];
   int          n_rows;
   logic [15:0] rnd [16];
   logic [15:0] lfsr;
   int          cycles;
   int          limit;

   assign rxd = txd;  // Loopback

   io_top UUT (
      .sysclk (sysclk), .rst (rst), .cs_comm (cs_comm), .cs_idbs (cs_idbs),
      .cs_valid (cs_valid), .idb_in (idb_in), .rxd (rxd), .baud_sel (baud_sel),
      .pan_word (pan_word), .pan_strobe (pan_strobe), .idb_out (idb_out),
      .txd (txd), .pan_out (pan_out),
      .bint10 (bint10), .bint12 (bint12), .bint13 (bint13)
   );

   io_checker result_check (
      .sysclk (sysclk), .check_en (check_en), .sig_sel (sig_sel),
      .exp_val (exp_val), .test_id (test_id), .test_done (test_done),
      .report (report), .idb_out (idb_out), .txd (txd), .pan_out (pan_out),
      .bint10 (bint10), .bint12 (bint12), .bint13 (bint13),
      .err_count (err_count), .check_count (check_count)
   );

   initial begin
      sysclk = 1'b0;
      forever #5 sysclk = ~sysclk;
   end

   // Fibonacci LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i] = lfsr[15];
         lfsr = lfsr_step(lfsr);
      end
   endtask

   task automatic add(input logic [3:0] kind, input logic [4:0] code, input logic [15:0] data,
                      input logic [15:0] exp, input logic [2:0] sig, input logic [4:0] slot,
                      input logic [7:0] test);
      row_t r;
      r.kind = kind;
      r.code = code;
      r.data = (slot != NO_SLOT) ? rnd[slot] : data;
      r.exp  = (slot != NO_SLOT) ? rnd[slot] : exp;
      r.sig  = sig;
      r.test = test;
      rows[n_rows] = r;
      n_rows++;
   endtask

   task automatic uart_loop(input logic [3:0] baud, input logic [4:0] slot, input logic [7:0] t);
      add(K_BAUD, 0, {12'd0, baud}, 0, S_IDB, NO_SLOT, t);
      add(K_WR, io_cmd_pkg::comm_uart_tx, 0, 0, S_IDB, slot, t);
      add(K_WAIT, 5'd0, 0, 0, S_IDB, NO_SLOT, t);  // rx available
      add(K_IDLE, 0, 0, 0, S_IDB, NO_SLOT, t);
      add(K_CHK, 0, 0, 16'd1, S_B10, NO_SLOT, t);
      add(K_RD, io_cmd_pkg::idbs_uart_rx, 0, 0, S_IDB, slot, t);
      add(K_WAIT, 5'd1, 0, 0, S_IDB, NO_SLOT, t);  // tx empty again
      add(K_RD, io_cmd_pkg::idbs_status, 0, 16'h0002, S_IDB, NO_SLOT, t);
   endtask

   task automatic build_table();
      n_rows = 0;
      // Test 1 covers the reset state
      add(K_RD, io_cmd_pkg::idbs_status, 0, 16'h0002, S_IDB, NO_SLOT, 1);
      add(K_RD, io_cmd_pkg::idbs_uart_rx, 0, 0, S_IDB, NO_SLOT, 1);
      add(K_RD, io_cmd_pkg::idbs_ctrl, 0, 0, S_IDB, NO_SLOT, 1);
      add(K_RD, io_cmd_pkg::idbs_pan_in, 0, 0, S_IDB, NO_SLOT, 1);
      add(K_RD, io_cmd_pkg::idbs_none, 0, 0, S_IDB, NO_SLOT, 1);
      add(K_CHK, 0, 0, 16'd1, S_TXD, NO_SLOT, 1);
      add(K_CHK, 0, 0, 0, S_B10, NO_SLOT, 1);
      add(K_CHK, 0, 0, 0, S_B12, NO_SLOT, 1);
      add(K_CHK, 0, 0, 0, S_B13, NO_SLOT, 1);
      add(K_END, 0, 0, 0, S_IDB, NO_SLOT, 1);
      // Test 2 covers the control register and tx interrupt
      add(K_WR, io_cmd_pkg::comm_ctrl, 0, 0, S_IDB, 5'd0, 2);
      add(K_RD, io_cmd_pkg::idbs_ctrl, 0, 0, S_IDB, 5'd0, 2);
      add(K_WR, io_cmd_pkg::comm_ctrl, 16'h0002, 0, S_IDB, NO_SLOT, 2);
      add(K_IDLE, 0, 0, 0, S_IDB, NO_SLOT, 2);
      add(K_CHK, 0, 0, 16'd1, S_B12, NO_SLOT, 2);
      add(K_WR, io_cmd_pkg::comm_ctrl, 16'h0000, 0, S_IDB, NO_SLOT, 2);
      add(K_IDLE, 0, 0, 0, S_IDB, NO_SLOT, 2);
      add(K_CHK, 0, 0, 0, S_B12, NO_SLOT, 2);
      add(K_END, 0, 0, 0, S_IDB, NO_SLOT, 2);
      // Test 3 runs UART loopback at two rates
      add(K_WR, io_cmd_pkg::comm_ctrl, 16'h0001, 0, S_IDB, NO_SLOT, 3);
      uart_loop(4'd0, 5'd1, 3);
      uart_loop(4'd2, 5'd2, 3);
      add(K_END, 0, 0, 0, S_IDB, NO_SLOT, 3);
      // Test 4 fills the panel FIFO and drops the fifth push
      add(K_WR, io_cmd_pkg::comm_ctrl, 16'h0004, 0, S_IDB, NO_SLOT, 4);
      for (int i = 3; i < 8; i++)
         add(K_PUSH, 0, 0, 0, S_IDB, 5'(i), 4);
      add(K_IDLE, 0, 0, 0, S_IDB, NO_SLOT, 4);
      add(K_RD, io_cmd_pkg::idbs_status, 0, 16'h0016, S_IDB, NO_SLOT, 4);
      add(K_CHK, 0, 0, 16'd1, S_B13, NO_SLOT, 4);
      for (int i = 3; i < 7; i++)
         add(K_RD, io_cmd_pkg::idbs_pan_in, 0, 0, S_IDB, 5'(i), 4);
      add(K_RD, io_cmd_pkg::idbs_pan_in, 0, 0, S_IDB, NO_SLOT, 4);
      add(K_IDLE, 0, 0, 0, S_IDB, NO_SLOT, 4);
      add(K_CHK, 0, 0, 0, S_B13, NO_SLOT, 4);
      add(K_END, 0, 0, 0, S_IDB, NO_SLOT, 4);
      // Test 5 covers the panel output latch and an unused command
      add(K_WR, io_cmd_pkg::comm_pan_out, 0, 0, S_IDB, 5'd8, 5);
      add(K_CHK, 0, 0, 0, S_PAN, 5'd8, 5);
      add(K_WR, 5'd13, 16'hffff, 0, S_IDB, NO_SLOT, 5);
      add(K_RD, io_cmd_pkg::idbs_ctrl, 0, 16'h0004, S_IDB, NO_SLOT, 5);
      add(K_RD, io_cmd_pkg::idbs_status, 0, 16'h0002, S_IDB, NO_SLOT, 5);
      add(K_CHK, 0, 0, 0, S_PAN, 5'd8, 5);
      add(K_WR, io_cmd_pkg::comm_pan_out, 0, 0, S_IDB, 5'd9, 5);
      add(K_CHK, 0, 0, 0, S_PAN, 5'd9, 5);
      add(K_END, 0, 0, 0, S_IDB, NO_SLOT, 5);
   endtask

   task automatic apply_row(input row_t r);
      cs_valid   = 1'b0;
      cs_comm    = '0;
      cs_idbs    = '0;
      pan_strobe = 1'b0;
      check_en   = 1'b0;
      test_done  = 1'b0;
      test_id    = r.test;
      case (r.kind)
         K_WR: begin
            cs_comm  = r.code;
            idb_in   = r.data;
            cs_valid = 1'b1;
         end
         K_RD: begin
            cs_idbs  = r.code;
            cs_valid = 1'b1;
            check_en = 1'b1;
            sig_sel  = S_IDB;
            exp_val  = r.exp;
         end
         K_PUSH: begin
            pan_word   = r.data;
            pan_strobe = 1'b1;
         end
         K_WAIT: begin
            cs_idbs  = io_cmd_pkg::idbs_status;
            cs_valid = 1'b1;
            @(negedge sysclk);
            while (!idb_out[r.code[3:0]])
               @(negedge sysclk);
         end
         K_CHK: begin
            check_en = 1'b1;
            sig_sel  = r.sig;
            exp_val  = r.exp;
         end
         K_BAUD:  baud_sel = r.data[3:0];
         K_END:   test_done = 1'b1;
         default: ;
      endcase
   endtask

   // Run limit
   always @(posedge sysclk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("Timeout after %0d cycles, DUT did not reach the expected state", cycles);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   initial begin
      rst        = 1'b1;
      cs_comm    = '0;
      cs_idbs    = '0;
      cs_valid   = 1'b0;
      idb_in     = '0;
      baud_sel   = '0;
      pan_word   = '0;
      pan_strobe = 1'b0;
      check_en   = 1'b0;
      sig_sel    = '0;
      exp_val    = '0;
      test_id    = '0;
      test_done  = 1'b0;
      report     = 1'b0;
      cycles     = 0;
      limit      = 0;
      lfsr       = 16'd96;
      for (int i = 0; i < 16; i++)
         take_bits((i == 1 || i == 2) ? 8 : 16, rnd[i]);
      build_table();
      limit = n_rows * (10 * (`IO_BAUD_BASE << 3)) + 200;
      repeat (8) @(posedge sysclk);
      @(negedge sysclk);
      rst = 1'b0;
      for (int i = 0; i < n_rows; i++) begin
         @(negedge sysclk);
         apply_row(rows[i]);
      end
      @(negedge sysclk);
      cs_valid  = 1'b0;
      check_en  = 1'b0;
      test_done = 1'b0;
      report    = 1'b1;
      @(negedge sysclk);
      report = 1'b0;
      if (err_count == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
